//--- sources.f
+incdir+dv
src/bridge_pkg.sv
src/uart_rx.sv
src/cmd_decode.sv
src/spi_master.sv
src/reply_queue.sv
src/uart_tx.sv
src/slm_bridge_top.sv
dv/bridge_tb.sv

//--- Makefile
# Verilator build and run for the serial command bridge

VERILATOR ?= verilator
TOP       ?= bridge_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

RTL_SRCS := src/bridge_pkg.sv src/uart_rx.sv src/cmd_decode.sv src/spi_master.sv \
            src/reply_queue.sv src/uart_tx.sv src/slm_bridge_top.sv
TB_SRCS  := dv/bridge_tb.sv dv/bridge_bfm.svh
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(RTL_SRCS) $(TB_SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

//--- dv/bridge_bfm.svh
// bridge bus models
`ifndef BRIDGE_BFM_SVH
`define BRIDGE_BFM_SVH

//////////////////////////////////////////////////
// spi slave state
//////////////////////////////////////////////////

logic      slave_in_frame = 1'b0;
logic      slave_sclk_q = 1'b0;
int        slave_bits = 0;
spi_word_t slave_word = '0;
byte_t     slave_reply = '0;

// xorshift32 step, caller keeps the state
function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// one 8n1 frame, lsb first, every bit exactly one bit time
task automatic uart_send_byte(input byte_t b);
  logic [9:0] frame;
  frame = {1'b1, b, 1'b0};
  for (int i = 0; i < 10; i++) begin
    @(posedge sys_clk);
    #1;
    uart_rx = frame[i];
    repeat (CLKS_PER_BIT - 1) @(posedge sys_clk);
  end
endtask

// hunt for start bit, then sample each bit in its middle
task automatic uart_recv_byte(output byte_t b, input int limit);
  int cycles;
  cycles = 0;
  b = '0;
  do begin
    @(posedge sys_clk);
    #1;
    cycles++;
    if (cycles > limit) begin
      abort_run("no UART start bit came from the DUT before the timeout");
    end
  end while (uart_tx);
  repeat (CLKS_PER_BIT / 2) @(posedge sys_clk);
  #1;
  check_equal(32'(uart_tx), 32'd0, "uart start bit at mid-bit");
  for (int i = 0; i < BYTE_W; i++) begin
    repeat (CLKS_PER_BIT) @(posedge sys_clk);
    #1;
    b[i] = uart_tx;
  end
  repeat (CLKS_PER_BIT) @(posedge sys_clk);
  #1;
  check_equal(32'(uart_tx), 32'd1, "uart stop bit");
endtask

// one cycle of the spi slave, called just after the clock edge
task automatic spi_slave_step();
  if (spi_cs_n) begin
    // frame over, hand it to the checker
    if (slave_in_frame) begin
      seen_frames.push_back(slave_word);
      seen_bits.push_back(slave_bits);
      slave_in_frame = 1'b0;
    end
    spi_miso = 1'b0;
  end else begin
    if (!slave_in_frame) begin
      slave_in_frame = 1'b1;
      slave_bits = 0;
      slave_word = '0;
    end
    if (spi_sclk && !slave_sclk_q) begin
      // mosi captured on rising sclk
      slave_word = {slave_word[SPI_WORD_W-2:0], spi_mosi};
      slave_bits++;
      if (slave_bits == BYTE_W) begin
        slave_reply = expected_reply(slave_word[BYTE_W-1:0]);
      end
    end else if (!spi_sclk && slave_sclk_q) begin
      // data half, reply msb first, moved on falling sclk
      if (slave_bits >= BYTE_W && slave_bits < SPI_WORD_W) begin
        spi_miso = slave_reply[SPI_WORD_W-1-slave_bits];
      end
    end
  end
  slave_sclk_q = spi_sclk;
endtask

`endif

//--- dv/bridge_tb.sv
// serial bridge testbench
`timescale 1ns/1ps

module bridge_tb;
  import bridge_pkg::*;

  localparam int RESET_CYCLES       = 4;
  localparam int RX_WAIT_CYCLES     = 60 * CLKS_PER_BIT;
  localparam int RESULT_WAIT_CYCLES = 200 * CLKS_PER_BIT;
  localparam int RANDOM_PAIRS       = 20;

  logic sys_clk;
  logic reset_all_cmd_w;
  logic uart_rx;
  logic uart_tx;
  logic spi_miso;
  logic spi_mosi;
  logic spi_sclk;
  logic spi_cs_n;
  logic slm_reset_n;

  // expected frames and replies in send order
  spi_word_t   exp_frames[$];
  byte_t       exp_replies[$];
  // what the bus models saw
  spi_word_t   seen_frames[$];
  int          seen_bits[$];
  byte_t       seen_replies[$];
  int          frames_done = 0;
  int          replies_done = 0;
  logic [31:0] rng_state;

  slm_bridge_top dut_i (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx),
    .uart_tx_o       (uart_tx),
    .spi_miso_i      (spi_miso),
    .spi_mosi_o      (spi_mosi),
    .spi_sclk_o      (spi_sclk),
    .spi_cs_n_o      (spi_cs_n),
    .slm_reset_n_o   (slm_reset_n)
  );

  initial begin
    sys_clk = 1'b0;
    forever #5 sys_clk = ~sys_clk;
  end

  //////////////////////////////////////////////////
  // reference and checks
  //////////////////////////////////////////////////

  // modulator answers each write with its address xor a5
  function automatic byte_t expected_reply(input byte_t addr);
    return addr ^ 8'hA5;
  endfunction

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("FAIL %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("** FAIL **");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic abort_run(input string why);
    $display("ERROR %0t ns: %s", $time, why);
    $display("** FAIL **");
    $fatal(1, "%s", why);
  endtask

  // record what the pair should produce and send it
  task automatic send_pair(input byte_t addr, input byte_t data);
    exp_frames.push_back({addr, data});
    exp_replies.push_back(expected_reply(addr));
    uart_send_byte(addr);
    uart_send_byte(data);
  endtask

  task automatic wait_results(input int n_frames, input int n_replies);
    int cycles;
    cycles = 0;
    while (frames_done < n_frames || replies_done < n_replies) begin
      @(posedge sys_clk);
      cycles++;
      if (cycles > RESULT_WAIT_CYCLES) begin
        abort_run("timed out waiting for SPI frames and UART replies");
      end
    end
  endtask

  // cycles from reset release until the modulator reset goes high
  task automatic measure_slm_release(output int cycles);
    cycles = 0;
    while (!slm_reset_n) begin
      @(posedge sys_clk);
      #1;
      cycles++;
      if (!slm_reset_n && cycles > 4 * RESET_HOLD_CYCLES) begin
        abort_run("modulator reset never released");
      end
    end
  endtask

  `include "bridge_bfm.svh"

  // spi slave and sclk idle rule every cycle
  always @(posedge sys_clk) begin
    #1;
    if (!reset_all_cmd_w) begin
      check_equal(32'(spi_cs_n & spi_sclk), 32'd0, "sclk high while cs high");
      spi_slave_step();
    end
  end

  // compare what was seen with the expectations
  always @(posedge sys_clk) begin
    spi_word_t got_word;
    int        got_bits;
    byte_t     got_byte;
    #2;
    while (seen_frames.size() > 0) begin
      got_word = seen_frames.pop_front();
      got_bits = seen_bits.pop_front();
      if (exp_frames.size() == 0) begin
        abort_run("SPI frame seen with no command sent");
      end
      check_equal(32'(got_bits), 32'(SPI_WORD_W), "spi frame length in bits");
      check_equal(32'(got_word), 32'(exp_frames.pop_front()), "spi frame address and data");
      frames_done++;
    end
    while (seen_replies.size() > 0) begin
      got_byte = seen_replies.pop_front();
      if (exp_replies.size() == 0) begin
        abort_run("UART reply seen with no command sent");
      end
      check_equal(32'(got_byte), 32'(exp_replies.pop_front()), "uart reply byte");
      replies_done++;
    end
  end

  //////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////

  initial begin
    int    release_cycles;
    byte_t reply;
    byte_t lone_addr;
    reset_all_cmd_w = 1'b1;
    uart_rx = 1'b1;
    spi_miso = 1'b0;
    rng_state = 32'h4b9c2dcb;

    // idle levels while reset is held
    repeat (RESET_CYCLES) begin
      @(posedge sys_clk);
      #1;
      check_equal(32'(spi_cs_n), 32'd1, "cs_n in reset");
      check_equal(32'(spi_sclk), 32'd0, "sclk in reset");
      check_equal(32'(uart_tx), 32'd1, "uart tx in reset");
      check_equal(32'(slm_reset_n), 32'd0, "modulator reset in reset");
    end
    reset_all_cmd_w = 1'b0;
    measure_slm_release(release_cycles);
    check_equal(32'(release_cycles), 32'(RESET_HOLD_CYCLES), "modulator reset hold cycles");
    check_equal(32'(spi_cs_n), 32'd1, "cs_n after reset");
    check_equal(32'(uart_tx), 32'd1, "uart tx after reset");

    // single pair and its reply
    send_pair(8'h09, 8'h32);
    uart_recv_byte(reply, RX_WAIT_CYCLES);
    seen_replies.push_back(reply);
    wait_results(1, 1);

    // lone byte must leave cs alone for 40 bit times
    lone_addr = 8'h5C;
    exp_frames.push_back({lone_addr, 8'hE1});
    exp_replies.push_back(expected_reply(lone_addr));
    uart_send_byte(lone_addr);
    repeat (40 * CLKS_PER_BIT) begin
      @(posedge sys_clk);
      #1;
      check_equal(32'(spi_cs_n), 32'd1, "cs_n after a lone byte");
    end
    uart_send_byte(8'hE1);
    uart_recv_byte(reply, RX_WAIT_CYCLES);
    seen_replies.push_back(reply);
    wait_results(2, 2);

    // random pairs back to back with replies collected alongside
    fork
      begin
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
          rng_state = xorshift32(rng_state);
          send_pair(rng_state[7:0], rng_state[15:8]);
        end
      end
      begin
        byte_t rx_byte;
        for (int i = 0; i < RANDOM_PAIRS; i++) begin
          uart_recv_byte(rx_byte, RX_WAIT_CYCLES);
          seen_replies.push_back(rx_byte);
        end
      end
    join
    wait_results(RANDOM_PAIRS + 2, RANDOM_PAIRS + 2);

    $display("** PASS **");
    $finish;
  end

endmodule

//--- src/slm_bridge_top.sv
// slm serial command bridge
`timescale 1ns/1ps

module slm_bridge_top (
  input  logic sys_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  input  logic spi_miso_i,
  output logic spi_mosi_o,
  output logic spi_sclk_o,
  output logic spi_cs_n_o,
  output logic slm_reset_n_o
);
  import bridge_pkg::*;

  // byte stream, rx to decode
  logic                   rx_valid;
  byte_t                  rx_byte;
  // command stream, decode to spi
  logic                   cmd_valid;
  logic                   cmd_ready;
  spi_cmd_t               cmd;
  // reply stream, spi to queue
  logic                   reply_valid;
  byte_t                  reply_byte;
  // transmit start, queue to tx
  logic                   tx_start;
  logic                   tx_busy;
  byte_t                  tx_byte;
  // modulator reset stretch
  logic [RESET_CNT_W-1:0] hold_cnt_q;
  logic                   slm_rst_n_q;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  uart_rx u_uart_rx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_serial_i     (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  cmd_decode u_cmd_decode (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .cmd_valid_o     (cmd_valid),
    .cmd_o           (cmd),
    .cmd_ready_i     (cmd_ready)
  );

  //////////////////////////////////////////////////
  // execute
  //////////////////////////////////////////////////

  spi_master u_spi_master (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .cmd_valid_i     (cmd_valid),
    .cmd_i           (cmd),
    .cmd_ready_o     (cmd_ready),
    .reply_valid_o   (reply_valid),
    .reply_byte_o    (reply_byte),
    .miso_i          (spi_miso_i),
    .mosi_o          (spi_mosi_o),
    .sclk_o          (spi_sclk_o),
    .cs_n_o          (spi_cs_n_o)
  );

  //////////////////////////////////////////////////
  // result
  //////////////////////////////////////////////////

  reply_queue u_reply_queue (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .reply_valid_i   (reply_valid),
    .reply_byte_i    (reply_byte),
    .tx_busy_i       (tx_busy),
    .tx_start_o      (tx_start),
    .tx_byte_o       (tx_byte)
  );

  uart_tx u_uart_tx (
    .sys_clk         (sys_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .tx_start_i      (tx_start),
    .tx_byte_i       (tx_byte),
    .tx_busy_o       (tx_busy),
    .tx_serial_o     (uart_tx_o)
  );

  // modulator reset, low in reset and for the hold time after it
  // counter loads hold-1 so release lands on the hold-th cycle
  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt_q  <= RESET_CNT_W'(RESET_HOLD_CYCLES - 1);
      slm_rst_n_q <= 1'b0;
    end else begin
      if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end
      // release once count has run out
      slm_rst_n_q <= (hold_cnt_q == '0);
    end
  end

  assign slm_reset_n_o = slm_rst_n_q;

endmodule

//--- src/uart_tx.sv
// uart transmitter, 8n1
`timescale 1ns/1ps

module uart_tx (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              tx_start_i,
  input  bridge_pkg::byte_t tx_byte_i,
  output logic              tx_busy_o,
  output logic              tx_serial_o
);
  import bridge_pkg::*;

  uart_state_e state_q;
  baud_cnt_t   baud_q;
  bit_cnt_t    bit_cnt_q;
  byte_t       data_q;
  logic        serial_q;
  logic        busy_q;
  // end of the current bit
  logic        bit_end;

  assign bit_end = (baud_q == baud_cnt_t'(CLKS_PER_BIT - 1));

  //////////////////////////////////////////////////
  // frame fsm
  //////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= UART_IDLE;
      baud_q    <= '0;
      bit_cnt_q <= '0;
      serial_q  <= 1'b1;
      busy_q    <= 1'b0;
    end else begin
      baud_q <= bit_end ? '0 : baud_q + 1'b1;
      case (state_q)
        UART_IDLE: begin
          baud_q   <= '0;
          serial_q <= 1'b1;
          // start bit on the line next cycle
          if (tx_start_i) begin
            serial_q <= 1'b0;
            busy_q   <= 1'b1;
            state_q  <= UART_START;
          end
        end
        UART_START: begin
          if (bit_end) begin
            bit_cnt_q <= '0;
            serial_q  <= data_q[0];
            state_q   <= UART_DATA;
          end
        end
        UART_DATA: begin
          // lsb first, next bit is at index 1 before the shift
          if (bit_end) begin
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == bit_cnt_t'(BYTE_W - 1)) begin
              serial_q <= 1'b1;
              state_q  <= UART_STOP;
            end else begin
              serial_q <= data_q[1];
            end
          end
        end
        UART_STOP: begin
          // busy held through the whole stop bit
          if (bit_end) begin
            busy_q  <= 1'b0;
            state_q <= UART_IDLE;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // byte latch and shift
  always_ff @(posedge sys_clk) begin
    if (state_q == UART_IDLE && tx_start_i) begin
      data_q <= tx_byte_i;
    end else if (state_q == UART_DATA && bit_end) begin
      data_q <= {1'b0, data_q[BYTE_W-1:1]};
    end
  end

  assign tx_busy_o   = busy_q;
  assign tx_serial_o = serial_q;

endmodule

//--- src/reply_queue.sv
// spi reply fifo to uart tx
`timescale 1ns/1ps

module reply_queue (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              reply_valid_i,
  input  bridge_pkg::byte_t reply_byte_i,
  input  logic              tx_busy_i,
  output logic              tx_start_o,
  output bridge_pkg::byte_t tx_byte_o
);
  import bridge_pkg::*;

  // circular buffer
  byte_t                  mem_q [REPLY_DEPTH];
  logic [REPLY_PTR_W-1:0] wr_ptr_q;
  logic [REPLY_PTR_W-1:0] rd_ptr_q;
  logic [REPLY_CNT_W-1:0] count_q;
  logic                   push;
  logic                   pop;
  logic                   tx_start_q;
  byte_t                  tx_byte_q;

  // full queue drops the reply
  assign push = reply_valid_i && (count_q != REPLY_CNT_W'(REPLY_DEPTH));
  // tx busy lags the start pulse by a cycle, so skip that cycle too
  assign pop  = (count_q != '0) && !tx_busy_i && !tx_start_q;

  //////////////////////////////////////////////////
  // pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      count_q    <= '0;
      tx_start_q <= 1'b0;
    end else begin
      // start goes out the cycle after the pop
      tx_start_q <= pop;
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // storage and output byte
  always_ff @(posedge sys_clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= reply_byte_i;
    end
    if (pop) begin
      tx_byte_q <= mem_q[rd_ptr_q];
    end
  end

  assign tx_start_o = tx_start_q;
  assign tx_byte_o  = tx_byte_q;

  a_count_bound : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    count_q <= REPLY_CNT_W'(REPLY_DEPTH)
  );

endmodule

//--- src/spi_master.sv
// spi mode 0 master, 16 bit
`timescale 1ns/1ps

module spi_master (
  input  logic                 sys_clk,
  input  logic                 reset_all_cmd_w,
  input  logic                 cmd_valid_i,
  input  bridge_pkg::spi_cmd_t cmd_i,
  output logic                 cmd_ready_o,
  output logic                 reply_valid_o,
  output bridge_pkg::byte_t    reply_byte_o,
  input  logic                 miso_i,
  output logic                 mosi_o,
  output logic                 sclk_o,
  output logic                 cs_n_o
);
  import bridge_pkg::*;

  spi_state_e           state_q;
  // half period divider
  logic [SPI_DIV_W-1:0] div_q;
  bit_cnt_t             bit_cnt_q;
  spi_word_t            shift_q;
  byte_t                rx_q;
  logic                 sclk_q;
  logic                 cs_n_q;
  logic                 reply_valid_q;
  // sclk edge strobes
  logic                 half_done;
  logic                 rise;
  logic                 fall;

  assign half_done = (state_q == SPI_SHIFT) && (div_q == SPI_DIV_W'(SPI_HALF_PERIOD - 1));
  assign rise      = half_done && !sclk_q;
  assign fall      = half_done && sclk_q;

  //////////////////////////////////////////////////
  // transfer fsm
  //////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q       <= SPI_IDLE;
      div_q         <= '0;
      bit_cnt_q     <= '0;
      shift_q       <= '0;
      sclk_q        <= 1'b0;
      cs_n_q        <= 1'b1;
      reply_valid_q <= 1'b0;
    end else begin
      reply_valid_q <= 1'b0;
      case (state_q)
        SPI_IDLE: begin
          // accept, cs drops next cycle with msb already on mosi
          if (cmd_valid_i) begin
            shift_q   <= spi_word_t'(cmd_i);
            div_q     <= '0;
            bit_cnt_q <= '0;
            cs_n_q    <= 1'b0;
            state_q   <= SPI_SHIFT;
          end
        end
        SPI_SHIFT: begin
          div_q <= half_done ? '0 : div_q + 1'b1;
          if (half_done) begin
            sclk_q <= ~sclk_q;
          end
          // mosi moves on the falling edge
          if (fall) begin
            shift_q   <= {shift_q[SPI_WORD_W-2:0], 1'b0};
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == bit_cnt_t'(SPI_WORD_W - 1)) begin
              state_q <= SPI_DONE;
            end
          end
        end
        SPI_DONE: begin
          // cs release and reply strobe together
          cs_n_q        <= 1'b1;
          reply_valid_q <= 1'b1;
          state_q       <= SPI_IDLE;
        end
        default: state_q <= SPI_IDLE;
      endcase
    end
  end

  // miso on rising edge, last eight samples are the data half
  always_ff @(posedge sys_clk) begin
    if (rise) begin
      rx_q <= {rx_q[BYTE_W-2:0], miso_i};
    end
  end

  assign cmd_ready_o   = (state_q == SPI_IDLE);
  assign reply_valid_o = reply_valid_q;
  assign reply_byte_o  = rx_q;
  assign mosi_o        = shift_q[SPI_WORD_W-1];
  assign sclk_o        = sclk_q;
  assign cs_n_o        = cs_n_q;

  // no clock edges outside a frame
  a_sclk_idle : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    cs_n_o |-> !sclk_o
  );

endmodule

//--- src/cmd_decode.sv
// byte pair to spi command
`timescale 1ns/1ps

module cmd_decode (
  input  logic                 sys_clk,
  input  logic                 reset_all_cmd_w,
  input  logic                 rx_valid_i,
  input  bridge_pkg::byte_t    rx_byte_i,
  output logic                 cmd_valid_o,
  output bridge_pkg::spi_cmd_t cmd_o,
  input  logic                 cmd_ready_i
);
  import bridge_pkg::*;

  // high once the address byte of a pair is in
  logic     have_addr_q;
  byte_t    addr_q;
  spi_cmd_t cmd_q;
  logic     cmd_valid_q;
  // second byte arrived and the slot is free
  logic     load_cmd;

  assign load_cmd = rx_valid_i && have_addr_q && (!cmd_valid_q || cmd_ready_i);

  //////////////////////////////////////////////////
  // pairing and handshake
  //////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      have_addr_q <= 1'b0;
      cmd_valid_q <= 1'b0;
    end else begin
      // spi master took it
      if (cmd_valid_q && cmd_ready_i) begin
        cmd_valid_q <= 1'b0;
      end
      // odd/even toggles on every byte
      if (rx_valid_i) begin
        have_addr_q <= ~have_addr_q;
      end
      // pair done, a still pending command keeps its slot
      if (load_cmd) begin
        cmd_valid_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rx_valid_i && !have_addr_q) begin
      addr_q <= rx_byte_i;
    end
    if (load_cmd) begin
      cmd_q.addr <= addr_q;
      cmd_q.data <= rx_byte_i;
    end
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = cmd_q;

  // held command must not change before the spi master takes it
  a_cmd_hold : assert property (
    @(posedge sys_clk) disable iff (reset_all_cmd_w)
    (cmd_valid_o && !cmd_ready_i) |=> (cmd_valid_o && $stable(cmd_o))
  );

endmodule

//--- src/uart_rx.sv
// uart receiver, 8n1
`timescale 1ns/1ps

module uart_rx (
  input  logic              sys_clk,
  input  logic              reset_all_cmd_w,
  input  logic              rx_serial_i,
  output logic              rx_valid_o,
  output bridge_pkg::byte_t rx_byte_o
);
  import bridge_pkg::*;

  // two flop sync on the async line
  logic        rx_meta_q;
  logic        rx_sync_q;
  uart_state_e state_q;
  baud_cnt_t   baud_q;
  bit_cnt_t    bit_cnt_q;
  byte_t       data_q;
  logic        valid_q;
  // mid-bit and full-bit strobes
  logic        half_bit;
  logic        full_bit;

  assign half_bit = (baud_q == baud_cnt_t'(CLKS_PER_BIT / 2 - 1));
  assign full_bit = (baud_q == baud_cnt_t'(CLKS_PER_BIT - 1));

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_serial_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  //////////////////////////////////////////////////
  // frame fsm
  //////////////////////////////////////////////////

  always_ff @(posedge sys_clk) begin
    if (reset_all_cmd_w) begin
      state_q   <= UART_IDLE;
      baud_q    <= '0;
      bit_cnt_q <= '0;
      valid_q   <= 1'b0;
    end else begin
      // valid is a single pulse
      valid_q <= 1'b0;
      baud_q  <= baud_q + 1'b1;
      case (state_q)
        UART_IDLE: begin
          baud_q <= '0;
          // falling start edge
          if (!rx_sync_q) begin
            state_q <= UART_START;
          end
        end
        UART_START: begin
          // recheck start at mid-bit, glitch goes back to idle
          if (half_bit) begin
            baud_q    <= '0;
            bit_cnt_q <= '0;
            state_q   <= rx_sync_q ? UART_IDLE : UART_DATA;
          end
        end
        UART_DATA: begin
          if (full_bit) begin
            baud_q    <= '0;
            bit_cnt_q <= bit_cnt_q + 1'b1;
            if (bit_cnt_q == bit_cnt_t'(BYTE_W - 1)) begin
              state_q <= UART_STOP;
            end
          end
        end
        UART_STOP: begin
          // middle of stop bit, framing error drops the byte
          if (full_bit) begin
            valid_q <= rx_sync_q;
            state_q <= UART_IDLE;
          end
        end
        default: state_q <= UART_IDLE;
      endcase
    end
  end

  // lsb first into the top of the shifter
  always_ff @(posedge sys_clk) begin
    if (state_q == UART_DATA && full_bit) begin
      data_q <= {rx_sync_q, data_q[BYTE_W-1:1]};
    end
  end

  assign rx_valid_o = valid_q;
  assign rx_byte_o  = data_q;

endmodule

//--- src/bridge_pkg.sv
// serial bridge shared definitions
package bridge_pkg;

  //////////////////////////////////////////////////
  // widths and timing
  //////////////////////////////////////////////////

  // one uart byte, also each spi half
  localparam int BYTE_W            = 8;
  localparam int SPI_WORD_W        = 16;
  // sim sized, board runs 868 at 100 MHz / 115200
  localparam int CLKS_PER_BIT      = 16;
  // sys_clk cycles per sclk half period
  localparam int SPI_HALF_PERIOD   = 2;
  localparam int SPI_DIV_W         = $clog2(SPI_HALF_PERIOD);
  // modulator min reset pulse width
  localparam int RESET_HOLD_CYCLES = 10;
  localparam int RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES);
  // reply fifo sizing
  localparam int REPLY_DEPTH       = 4;
  localparam int REPLY_PTR_W       = $clog2(REPLY_DEPTH);
  localparam int REPLY_CNT_W       = $clog2(REPLY_DEPTH + 1);

  //////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////

  typedef logic [BYTE_W-1:0]                  byte_t;
  // address in upper half, shifted msb first
  typedef logic [SPI_WORD_W-1:0]              spi_word_t;
  // counts uart bits and spi bits
  typedef logic [3:0]                         bit_cnt_t;
  typedef logic [$clog2(CLKS_PER_BIT+1)-1:0] baud_cnt_t;

  // one register write, addr goes out first
  typedef struct packed {
    byte_t addr;
    byte_t data;
  } spi_cmd_t;

  typedef enum logic [1:0] {UART_IDLE, UART_START, UART_DATA, UART_STOP} uart_state_e;
  typedef enum logic [1:0] {SPI_IDLE, SPI_SHIFT, SPI_DONE} spi_state_e;

endpackage
